// ==== include/tx_settings.svh ====
/* Transmit path sizing macros
   Packet width, arbitrated source count, link beat width and frame length */

`ifndef TX_SETTINGS_SVH
`define TX_SETTINGS_SVH

// Full packet, header plus payload
`define TX_PW 72

// Sources seen by the arbiter (wr, rd, rr, dma)
`define TX_CH 4

// Link byte lane
`define TX_LW 8

// Beats per frame, TX_PW / TX_LW
`define TX_BEATS 9

`endif

// ==== logic/tx_pkg.sv ====
/* Transmit path types
   Payload union, packet header struct, source index enum */

package tx_pkg;

  // ################################################
  // Payload word
  // ################################################

  // Same 32 bits, meaning depends on the packet kind
  typedef union packed {
    // Data word carried by a write
    logic [31:0] write_data;
    // Where the far side sends the read response
    logic [31:0] return_addr;
  } tx_payload_u;

  // ################################################
  // Packet header
  // ################################################

  // 72-bit packet, msb first
  typedef struct packed {
    // Bits 71:40
    tx_payload_u payload;
    // Bits 39:8
    logic [31:0] dst_addr;
    // Bits 7:4, may be overridden in bypass mode
    logic [3:0]  ctrlmode;
    // Bits 3:2, access size
    logic [1:0]  datamode;
    // Bit 1, set for writes
    logic        write;
    // Bit 0, unused
    logic        spare;
  } tx_hdr_t;

  // ################################################
  // Source index
  // ################################################

  // Listed in priority order, index 0 wins
  typedef enum logic [1:0] {
    ch_wr,
    ch_rd,
    ch_rr,
    ch_dma
  } tx_ch_e;

endpackage

// ==== logic/tx_ctrlmode_stamp.sv ====
/* Input side of the transmit path
   Config register for ctrlmode bypass and header stamping of wr/rd packets */

`timescale 1ns/10ps

`include "tx_settings.svh"

module tx_ctrlmode_stamp (
  input  logic              clk,
  input  logic              rst_n,
  // Config write strobe and values
  input  logic              cfg_we,
  input  logic              bypass_in,
  input  logic [3:0]        ctrlmode_in,
  // Raw packets from the write and read-request sources
  input  logic [`TX_PW-1:0] wr_packet,
  input  logic [`TX_PW-1:0] rd_packet,
  // Packets with ctrlmode replaced when bypass is on
  output logic [`TX_PW-1:0] wr_stamped,
  output logic [`TX_PW-1:0] rd_stamped
);

  // Registered config
  logic       bypass_q;
  logic [3:0] ctrlmode_q;

  // Rebuild header with the configured ctrlmode
  function automatic tx_pkg::tx_hdr_t stamp(
    input logic [`TX_PW-1:0] pkt,
    input logic              bypass,
    input logic [3:0]        mode
  );
    tx_pkg::tx_hdr_t hdr;
    hdr = pkt;
    // Only the ctrlmode nibble changes
    if (bypass)
    begin
      hdr.ctrlmode = mode;
    end
    return hdr;
  endfunction

  // ################################################
  // Config register
  // ################################################

  // New values apply from the cycle after cfg_we
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bypass_q   <= 1'b0;
      ctrlmode_q <= 4'h0;
    end
    else if (cfg_we)
    begin
      bypass_q   <= bypass_in;
      ctrlmode_q <= ctrlmode_in;
    end
  end

  // ################################################
  // Stamping
  // ################################################

  // Combinational, rr and dma bypass this block entirely
  assign wr_stamped = stamp(wr_packet, bypass_q, ctrlmode_q);
  assign rd_stamped = stamp(rd_packet, bypass_q, ctrlmode_q);

endmodule

// ==== logic/tx_priority_arbiter.sv ====
/* Fixed-priority request/grant logic
   Lowest index wins, losers flagged per channel */

`timescale 1ns/10ps

module tx_priority_arbiter #(
  parameter int N = 4
) (
  // One bit per source, bit 0 has top priority
  input  logic [N-1:0] request,
  // One-hot grant, or zero when nobody asks
  output logic [N-1:0] grant,
  // Asked but not granted this cycle
  output logic [N-1:0] lose
);

  // ################################################
  // Grant chain
  // ################################################

  always_comb
  begin
    logic taken;
    taken = 1'b0;
    grant = '0;
    // Walk from highest priority down
    for (int i = 0; i < N; i++)
    begin
      if (request[i] && !taken)
      begin
        grant[i] = 1'b1;
        taken    = 1'b1;
      end
    end
  end

  // Everyone else that asked has to wait
  assign lose = request & ~grant;

  // ################################################
  // Checks
  // ################################################

  // At most one winner, and only a requester can win
  always_comb
  begin
    a_grant_onehot: assert ($onehot0(grant) && ((grant & ~request) == '0))
      else $error("tx_priority_arbiter: bad grant %b for request %b", grant, request);
  end

endmodule

// ==== logic/tx_arbiter.sv ====
/* Processing part of the transmit path
   Source arbitration, wait levels, read credit and output pipeline register */

`timescale 1ns/10ps

`include "tx_settings.svh"

module tx_arbiter (
  input  logic              clk,
  input  logic              rst_n,
  // Host writes, highest priority
  input  logic              wr_access,
  input  logic [`TX_PW-1:0] wr_packet,
  output logic              wr_wait,
  // Host read requests
  input  logic              rd_access,
  input  logic [`TX_PW-1:0] rd_packet,
  output logic              rd_wait,
  // Read responses
  input  logic              rr_access,
  input  logic [`TX_PW-1:0] rr_packet,
  output logic              rr_wait,
  // DMA channel, lowest priority
  input  logic              dma_access,
  input  logic [`TX_PW-1:0] dma_packet,
  output logic              dma_wait,
  // Global stall and far-side read completion pulse
  input  logic              cfg_wait,
  input  logic              rd_done,
  // Serializer pops the output register
  input  logic              take,
  output logic              out_valid,
  output logic [`TX_PW-1:0] out_packet,
  output logic              out_rr
);

  logic [`TX_CH-1:0] request;
  logic [`TX_CH-1:0] grant;
  logic [`TX_CH-1:0] lose;
  logic [`TX_PW-1:0] mux_packet;
  // One read in flight at a time
  logic              rd_credit;
  // Register full and not draining this cycle
  logic              stall;
  logic              load;

  // ################################################
  // Arbitration
  // ################################################

  // Blocked read requests drop out so lower sources can proceed
  assign request[tx_pkg::ch_wr]  = wr_access;
  assign request[tx_pkg::ch_rd]  = rd_access & ~rd_credit;
  assign request[tx_pkg::ch_rr]  = rr_access;
  assign request[tx_pkg::ch_dma] = dma_access;

  tx_priority_arbiter #(
    .N(`TX_CH)
  ) tx_priority_arbiter_inst (
    .request(request),
    .grant  (grant),
    .lose   (lose)
  );

  // AND-OR mux, grant is one-hot
  assign mux_packet = ({`TX_PW{grant[tx_pkg::ch_wr]}}  & wr_packet)  |
                      ({`TX_PW{grant[tx_pkg::ch_rd]}}  & rd_packet)  |
                      ({`TX_PW{grant[tx_pkg::ch_rr]}}  & rr_packet)  |
                      ({`TX_PW{grant[tx_pkg::ch_dma]}} & dma_packet);

  // ################################################
  // Wait levels
  // ################################################

  assign stall = out_valid & ~take;

  // Winner is taken only when nothing stalls the pipe
  assign load = (|grant) & ~cfg_wait & ~stall;

  assign wr_wait  = lose[tx_pkg::ch_wr]  | cfg_wait | stall;
  // Outstanding read holds off further requests
  assign rd_wait  = lose[tx_pkg::ch_rd]  | cfg_wait | stall | rd_credit;
  assign rr_wait  = lose[tx_pkg::ch_rr]  | cfg_wait | stall;
  assign dma_wait = lose[tx_pkg::ch_dma] | cfg_wait | stall;

  // ################################################
  // Output register and read credit
  // ################################################

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid <= 1'b0;
      rd_credit <= 1'b0;
    end
    else
    begin
      out_valid <= load | stall;
      // Set on send, cleared by the far side
      if (load && grant[tx_pkg::ch_rd])
        rd_credit <= 1'b1;
      else if (rd_done)
        rd_credit <= 1'b0;
    end
  end

  // Packet and rr tag only qualified by out_valid
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      out_packet <= mux_packet;
      out_rr     <= grant[tx_pkg::ch_rr];
    end
  end

  // Serializer never pops an empty register
  a_take_valid: assert property (@(posedge clk) disable iff (!rst_n)
    take |-> out_valid);

  // Held packet is not overwritten before it drains
  a_hold_full: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !take |=> out_valid && $stable(out_packet) && $stable(out_rr));

endmodule

// ==== logic/tx_link_serializer.sv ====
/* Output side of the transmit path
   Shifts a packet onto the byte link, lsb first, framed by link_frame */

`timescale 1ns/10ps

`include "tx_settings.svh"

module tx_link_serializer (
  input  logic              clk,
  input  logic              rst_n,
  // From the output register of the arbiter
  input  logic              out_valid,
  input  logic [`TX_PW-1:0] out_packet,
  input  logic              out_rr,
  // Pop strobe back to the arbiter
  output logic              take,
  // Link pins
  output logic              link_frame,
  output logic [`TX_LW-1:0] link_data,
  output logic              link_rr
);

  localparam int LAST  = `TX_BEATS - 1;
  localparam int CNT_W = $clog2(`TX_BEATS);

  // Frame in progress
  logic               busy;
  logic [CNT_W-1:0]   beat_cnt;
  logic               last_beat;
  logic [`TX_PW-1:0]  shift_q;
  logic               rr_q;
  // Incoming packet seen as header fields
  tx_pkg::tx_hdr_t    in_hdr;

  assign in_hdr = out_packet;

  // ################################################
  // Frame control
  // ################################################

  assign last_beat = busy && (beat_cnt == CNT_W'(LAST));

  // Accept when idle, or on the last beat for back-to-back frames
  assign take = out_valid && (!busy || last_beat);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      beat_cnt <= '0;
    end
    else if (take)
    begin
      busy     <= 1'b1;
      beat_cnt <= '0;
    end
    else if (last_beat)
    begin
      busy     <= 1'b0;
      beat_cnt <= '0;
    end
    else if (busy)
    begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // ################################################
  // Shift register
  // ################################################

  // Low byte always on the pins, shift right each beat
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      shift_q <= out_packet;
      rr_q    <= out_rr;
    end
    else if (busy)
    begin
      shift_q <= {{`TX_LW{1'b0}}, shift_q[`TX_PW-1:`TX_LW]};
    end
  end

  assign link_frame = busy;
  assign link_data  = shift_q[`TX_LW-1:0];
  // rr tag only meaningful inside a frame
  assign link_rr    = busy & rr_q;

  // ################################################
  // Checks
  // ################################################

  // Frame lasts TX_BEATS cycles, no early pop
  a_frame_len: assert property (@(posedge clk) disable iff (!rst_n)
    take |=> (link_frame && !take) [*LAST] ##1 link_frame);

  // Write data low byte lands on beat 5
  a_wr_data: assert property (@(posedge clk) disable iff (!rst_n)
    take && in_hdr.write |->
      ##6 link_data == $past(in_hdr.payload.write_data[7:0], 6));

  // Return address top byte on the final beat of a read request
  a_rd_addr: assert property (@(posedge clk) disable iff (!rst_n)
    take && !in_hdr.write && !out_rr |->
      ##9 link_data == $past(in_hdr.payload.return_addr[31:24], 9));

endmodule

// ==== logic/tx_top.sv ====
/* Transmit path top level
   Ctrlmode stamping, arbitration with output register, byte-link serializer */

`timescale 1ns/10ps

`include "tx_settings.svh"

module tx_top (
  input  logic              clk,
  input  logic              rst_n,
  // Host writes
  input  logic              wr_access,
  input  logic [`TX_PW-1:0] wr_packet,
  output logic              wr_wait,
  // Host read requests
  input  logic              rd_access,
  input  logic [`TX_PW-1:0] rd_packet,
  output logic              rd_wait,
  // Read responses
  input  logic              rr_access,
  input  logic [`TX_PW-1:0] rr_packet,
  output logic              rr_wait,
  // DMA arbitration input
  input  logic              dma_access,
  input  logic [`TX_PW-1:0] dma_packet,
  output logic              dma_wait,
  // Stall and read completion
  input  logic              cfg_wait,
  input  logic              rd_done,
  // Ctrlmode config write
  input  logic              cfg_we,
  input  logic              bypass_in,
  input  logic [3:0]        ctrlmode_in,
  // Link output
  output logic              link_frame,
  output logic [`TX_LW-1:0] link_data,
  output logic              link_rr
);

  // Stamped packets into the arbiter
  logic [`TX_PW-1:0] wr_stamped;
  logic [`TX_PW-1:0] rd_stamped;
  // Output register to serializer
  logic              out_valid;
  logic [`TX_PW-1:0] out_packet;
  logic              out_rr;
  logic              take;

  // ################################################
  // Input side
  // ################################################

  tx_ctrlmode_stamp tx_ctrlmode_stamp_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_we     (cfg_we),
    .bypass_in  (bypass_in),
    .ctrlmode_in(ctrlmode_in),
    .wr_packet  (wr_packet),
    .rd_packet  (rd_packet),
    .wr_stamped (wr_stamped),
    .rd_stamped (rd_stamped)
  );

  // ################################################
  // Processing part
  // ################################################

  // rr and dma go straight in, unstamped
  tx_arbiter tx_arbiter_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_access (wr_access),
    .wr_packet (wr_stamped),
    .wr_wait   (wr_wait),
    .rd_access (rd_access),
    .rd_packet (rd_stamped),
    .rd_wait   (rd_wait),
    .rr_access (rr_access),
    .rr_packet (rr_packet),
    .rr_wait   (rr_wait),
    .dma_access(dma_access),
    .dma_packet(dma_packet),
    .dma_wait  (dma_wait),
    .cfg_wait  (cfg_wait),
    .rd_done   (rd_done),
    .take      (take),
    .out_valid (out_valid),
    .out_packet(out_packet),
    .out_rr    (out_rr)
  );

  // ################################################
  // Output side
  // ################################################

  tx_link_serializer tx_link_serializer_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_packet(out_packet),
    .out_rr    (out_rr),
    .take      (take),
    .link_frame(link_frame),
    .link_data (link_data),
    .link_rr   (link_rr)
  );

endmodule

// ==== verification/tx_tb.sv ====
/* Self-checking testbench for the transmit path
   Golden-file stimulus, link frame monitor, per-test and closing reports */

`timescale 1ns/10ps

`include "tx_settings.svh"

module tx_tb;

  localparam int MAX_EXP    = 8;
  localparam int RUN_LIMIT  = 400;
  localparam int IDLE_LIMIT = 40;

  logic              clk;
  logic              rst_n;
  logic              wr_access;
  logic              rd_access;
  logic              rr_access;
  logic              dma_access;
  logic [`TX_PW-1:0] wr_packet;
  logic [`TX_PW-1:0] rd_packet;
  logic [`TX_PW-1:0] rr_packet;
  logic [`TX_PW-1:0] dma_packet;
  logic              wr_wait;
  logic              rd_wait;
  logic              rr_wait;
  logic              dma_wait;
  logic              cfg_wait;
  logic              rd_done;
  logic              cfg_we;
  logic              bypass_in;
  logic [3:0]        ctrlmode_in;
  logic              link_frame;
  logic [`TX_LW-1:0] link_data;
  logic              link_rr;

  // Frames rebuilt from the link in arrival order
  logic [`TX_PW-1:0] got_pkt[$];
  logic              got_rr[$];
  logic [`TX_PW-1:0] asm_pkt;
  logic              asm_rr;
  int                beat;
  // Expected frames of the current record
  logic [`TX_PW-1:0] exp_pkt[MAX_EXP];
  logic              exp_rr[MAX_EXP];
  // Cycle within a test and the first cycle a frame may start in
  int                cyc;
  int                quiet;
  int                test_errs;
  int                total_errs;
  int                tests_run;
  int                tests_failed;
  logic              timed_out;

  tx_top tx_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_access  (wr_access),
    .wr_packet  (wr_packet),
    .wr_wait    (wr_wait),
    .rd_access  (rd_access),
    .rd_packet  (rd_packet),
    .rd_wait    (rd_wait),
    .rr_access  (rr_access),
    .rr_packet  (rr_packet),
    .rr_wait    (rr_wait),
    .dma_access (dma_access),
    .dma_packet (dma_packet),
    .dma_wait   (dma_wait),
    .cfg_wait   (cfg_wait),
    .rd_done    (rd_done),
    .cfg_we     (cfg_we),
    .bypass_in  (bypass_in),
    .ctrlmode_in(ctrlmode_in),
    .link_frame (link_frame),
    .link_data  (link_data),
    .link_rr    (link_rr)
  );

  // 10 ns clock
  initial
  begin
    clk = 1'b0;
    forever
    begin
      #5 clk = ~clk;
    end
  end

  // ################################################
  // Link monitor
  // ################################################

  // Collect beats into frames and check the framing
  always @(negedge clk)
  begin
    if (link_frame)
    begin
      if (beat == 0)
      begin
        asm_rr = link_rr;
        assert (cyc >= quiet)
          else
          begin
            $display("frame started in cycle %0d, before cycle %0d", cyc, quiet);
            test_errs++;
          end
      end
      assert (link_rr == asm_rr)
        else
        begin
          $display("link_rr changed in the middle of a frame");
          test_errs++;
        end
      // Lsb byte arrives first
      asm_pkt[beat*`TX_LW +: `TX_LW] = link_data;
      if (beat == `TX_BEATS - 1)
      begin
        got_pkt.push_back(asm_pkt);
        got_rr.push_back(asm_rr);
        beat = 0;
      end
      else
        beat++;
    end
    else
    begin
      assert (beat == 0)
        else
        begin
          $display("frame ended after %0d beats", beat);
          test_errs++;
        end
      assert (!link_rr)
        else
        begin
          $display("link_rr high outside a frame");
          test_errs++;
        end
      beat = 0;
    end
  end

  // ################################################
  // Golden file access
  // ################################################

  // Next line that is neither blank nor a comment
  task automatic read_record(input int fd, output string line, output logic found);
    string raw;
    int    n;
    found = 1'b0;
    line  = "";
    while (!found && !$feof(fd))
    begin
      n = $fgets(raw, fd);
      if (n > 1 && raw.substr(0, 0) != "#")
      begin
        line  = raw;
        found = 1'b1;
      end
    end
  endtask

  // ################################################
  // One test record
  // ################################################

  task automatic run_test(
    input string      name,
    input logic [3:0] acc,
    input logic       we,
    input logic       byp,
    input logic [3:0] mode,
    input int         wait_cycles,
    input int         done_cycle,
    input int         nexp
  );
    logic [3:0] pend;
    logic [3:0] waits;
    int         limit;
    test_errs = 0;
    got_pkt.delete();
    got_rr.delete();
    // Config write lands one cycle ahead of the packets
    @(negedge clk);
    cfg_we      = we;
    bypass_in   = byp;
    ctrlmode_in = mode;
    @(negedge clk);
    cfg_we = 1'b0;
    pend   = acc;
    cyc    = 0;
    while (!timed_out && (pend != 4'b0 || got_pkt.size() < nexp ||
           cyc <= done_cycle || cyc < wait_cycles))
    begin
      // Each source holds access until its own wait drops
      wr_access  = pend[0];
      rd_access  = pend[1];
      rr_access  = pend[2];
      dma_access = pend[3];
      cfg_wait   = (cyc < wait_cycles);
      rd_done    = (done_cycle > 0) && (cyc == done_cycle);
      @(posedge clk);
      waits = {dma_wait, rr_wait, rd_wait, wr_wait};
      if (cfg_wait)
      begin
        assert ((pend & ~waits) == 4'b0)
          else
          begin
            $display("test %s: a source was taken while cfg_wait was high", name);
            test_errs++;
          end
      end
      pend = pend & waits;
      cyc++;
      if (cyc > RUN_LIMIT)
      begin
        $display("test %s timed out after %0d cycles with frames missing", name, cyc);
        timed_out = 1'b1;
        test_errs++;
      end
      @(negedge clk);
    end
    wr_access  = 1'b0;
    rd_access  = 1'b0;
    rr_access  = 1'b0;
    dma_access = 1'b0;
    cfg_wait   = 1'b0;
    rd_done    = 1'b0;
    // Let the last frame finish
    limit = 0;
    while (link_frame && !timed_out)
    begin
      @(negedge clk);
      limit++;
      if (limit > IDLE_LIMIT)
      begin
        $display("test %s: link stayed busy after the last frame", name);
        timed_out = 1'b1;
        test_errs++;
      end
    end
    assert (got_pkt.size() == nexp)
      else
      begin
        $display("ERR %s frame count: expected %0d actual %0d", name, nexp, got_pkt.size());
        test_errs++;
      end
    for (int k = 0; k < nexp && k < got_pkt.size(); k++)
    begin
      assert (got_pkt[k] == exp_pkt[k])
        else
        begin
          $display("ERR %s frame %0d: expected %h actual %h", name, k, exp_pkt[k], got_pkt[k]);
          test_errs++;
        end
      assert (got_rr[k] == exp_rr[k])
        else
        begin
          $display("ERR %s frame %0d link_rr: expected %b actual %b", name, k, exp_rr[k],
                   got_rr[k]);
          test_errs++;
        end
    end
    $display("test %s: %s, %0d errors", name, (test_errs == 0) ? "ok" : "FAILED", test_errs);
    tests_run++;
    if (test_errs != 0)
      tests_failed++;
    total_errs += test_errs;
  endtask

  // ################################################
  // Main sequence
  // ################################################

  initial
  begin
    int         fd;
    int         n;
    string      line;
    string      kind;
    string      name;
    logic       found;
    logic       rec_ok;
    logic [3:0] acc;
    logic       we;
    logic       byp;
    logic [3:0] mode;
    int         wait_cycles;
    int         done_cycle;
    int         quiet_cycles;
    int         nexp;
    rst_n        = 1'b0;
    wr_access    = 1'b0;
    rd_access    = 1'b0;
    rr_access    = 1'b0;
    dma_access   = 1'b0;
    wr_packet    = '0;
    rd_packet    = '0;
    rr_packet    = '0;
    dma_packet   = '0;
    cfg_wait     = 1'b0;
    rd_done      = 1'b0;
    cfg_we       = 1'b0;
    bypass_in    = 1'b0;
    ctrlmode_in  = 4'h0;
    asm_pkt      = '0;
    asm_rr       = 1'b0;
    beat         = 0;
    cyc          = 0;
    quiet        = 0;
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // Idle sources and an empty pipe leave every wait low
    assert ({wr_wait, rd_wait, rr_wait, dma_wait} == 4'b0)
      else
      begin
        $display("ERR reset waits: expected %b actual %b", 4'b0,
                 {wr_wait, rd_wait, rr_wait, dma_wait});
        total_errs++;
      end
    fd = $fopen("verification/tx_golden.dat", "r");
    if (fd == 0)
    begin
      $display("cannot open verification/tx_golden.dat");
      total_errs++;
    end
    else
    begin
      read_record(fd, line, found);
      while (found && !timed_out)
      begin
        n = $sscanf(line, "%s %s %h %h %h %h %d %d %d %d", kind, name, acc, we, byp, mode,
                    wait_cycles, done_cycle, quiet_cycles, nexp);
        if (n != 10 || kind != "T" || nexp > MAX_EXP)
        begin
          $display("malformed test record in golden file: %s", line);
          total_errs++;
          found = 1'b0;
        end
        else
        begin
          rec_ok = 1'b1;
          // Packet line, then one line per expected frame
          read_record(fd, line, found);
          n = $sscanf(line, "%s %h %h %h %h", kind, wr_packet, rd_packet, rr_packet,
                      dma_packet);
          if (!found || n != 5 || kind != "P")
            rec_ok = 1'b0;
          for (int k = 0; k < nexp; k++)
          begin
            read_record(fd, line, found);
            n = $sscanf(line, "%s %h %h", kind, exp_pkt[k], exp_rr[k]);
            if (!found || n != 3 || kind != "E")
              rec_ok = 1'b0;
          end
          if (!rec_ok)
          begin
            $display("test record %s in golden file lacks its packet or frame lines", name);
            total_errs++;
            found = 1'b0;
          end
          else
          begin
            quiet = quiet_cycles;
            run_test(name, acc, we, byp, mode, wait_cycles, done_cycle, nexp);
            read_record(fd, line, found);
          end
        end
      end
      $fclose(fd);
    end
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errs);
    if (total_errs == 0 && !timed_out && tests_run > 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// ==== verification/tx_golden.dat ====
# T name access(bit0 wr, bit1 rd, bit2 rr, bit3 dma) cfg_we bypass ctrlmode
#   cfg_wait_cycles rd_done_cycle quiet_cycles frames
# P wr_packet rd_packet rr_packet dma_packet, 72-bit hex
# E expected_frame link_rr, one line per frame in link order

# All four at once, released in priority order
T priority F 0 0 0 0 30 0 4
P 11111111A00001002A 22222222A000020038 33333333B00003004A 44444444C00004005A
E 11111111A00001002A 0
E 22222222A000020038 0
E 33333333B00003004A 1
E 44444444C00004005A 0

# Bypass on with ctrlmode C, rr and dma keep their own
T bypass F 1 1 C 0 30 0 4
P 55555555A00005002A 66666666A000060038 77777777B00007004A 88888888C00008005A
E 55555555A0000500CA 0
E 66666666A0000600C8 0
E 77777777B00007004A 1
E 88888888C00008005A 0

# Bypass off again, one read leaves its credit set
T rd_first 2 1 0 0 0 0 0 1
P 000000000000000000 99999999A000090038 000000000000000000 000000000000000000
E 99999999A000090038 0

# Second read held until rd_done in cycle 20
T rd_throttle 2 0 0 0 0 20 20 1
P 000000000000000000 ABABABABA0000A0038 000000000000000000 000000000000000000
E ABABABABA0000A0038 0

# Global stall for 20 cycles, credit freed meanwhile
T cfg_stall F 0 0 0 20 5 20 4
P 12345678D00000102A 23456789D000002038 3456789AE00000304A 456789ABF00000405A
E 12345678D00000102A 0
E 23456789D000002038 0
E 3456789AE00000304A 1
E 456789ABF00000405A 0

# Distinct bytes for beat order, rr flag on the middle frame only
T format D 0 0 0 0 0 0 3
P 0123456789ABCDEF0A 000000000000000000 FEDCBA98765432104A A5A5A5A55A5A5A5A18
E 0123456789ABCDEF0A 0
E FEDCBA98765432104A 1
E A5A5A5A55A5A5A5A18 0

// ==== files.f ====
+incdir+include
logic/tx_pkg.sv
logic/tx_ctrlmode_stamp.sv
logic/tx_priority_arbiter.sv
logic/tx_arbiter.sv
logic/tx_link_serializer.sv
logic/tx_top.sv
verification/tx_tb.sv

// ==== Makefile ====
# Verilator flow for the transmit path testbench

TOP = tx_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -f files.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "sim passed" $(LOG) || (echo "run incomplete, see $(LOG)"; exit 1)

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
